// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = int_exec_tb
FILELIST = list.f

SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// File: dv/int_exec_checker.sv
// ================================================
// Integer execute checker
// Queues the expected ALU and multiply/divide
// results and compares them with the DUT outputs
// ================================================

`timescale 1ns/1ps
`include "int_exec_defines.svh"

module int_exec_checker (
  input  logic              clk,
  input  logic              reset,
  input  logic              exp_valid,
  input  logic              exp_md,
  input  logic [`XLEN-1:0]  exp_result,
  input  logic [4:0]        exp_rd,
  input  logic              exp_illegal,
  input  logic              end_check,
  input  logic              alu_done,
  input  logic [`XLEN-1:0]  alu_result,
  input  logic [4:0]        alu_rd,
  input  logic              alu_illegal,
  input  logic              md_busy,
  input  logic              md_done,
  input  logic [`XLEN-1:0]  md_result,
  input  logic [4:0]        md_rd,
  output int                mismatch_count,
  output int                other_count
);

  // ALU entries are {illegal, rd, result}, mul/div entries are {rd, result}
  logic [`XLEN+5:0] alu_q [$];
  longint           alu_cycle_q [$];
  logic [`XLEN+4:0] md_q [$];
  longint           cycle = 0;
  int               mismatch_errs = 0;
  int               protocol_errs = 0;
  int               leftover_errs = 0;

  assign mismatch_count = mismatch_errs;
  assign other_count    = protocol_errs + leftover_errs;

  // Outputs are read on the clock edge, before the DUT registers update
  always @(posedge clk) begin
    logic [`XLEN+5:0] a_exp;
    logic [`XLEN+4:0] m_exp;
    longint           a_cyc;
    if (reset) begin
      cycle = 0;
    end else begin
      cycle = cycle + 1;
      // The unit may only be busy while a multiply or divide is in flight
      if (md_busy && md_q.size() == 0) begin
        $display("error at %0t: md_busy is high with no multiply/divide issued", $time);
        protocol_errs++;
      end
      // Between the issue and its md_done the unit has to stay busy
      if (!md_busy && !md_done && md_q.size() != 0) begin
        $display("error at %0t: md_busy is low with a multiply/divide outstanding", $time);
        protocol_errs++;
      end
      if (alu_done) begin
        if (alu_q.size() == 0) begin
          $display("error at %0t: alu_done pulsed with no ALU issue outstanding", $time);
          protocol_errs++;
        end else begin
          a_exp = alu_q.pop_front();
          a_cyc = alu_cycle_q.pop_front();
          // The ALU result belongs to the issue taken one edge earlier
          if (cycle != a_cyc + 1) begin
            $display("error at %0t: alu_done came %0d cycles after its issue",
                     $time, cycle - a_cyc);
            protocol_errs++;
          end
          if ({alu_illegal, alu_rd, alu_result} !== a_exp) begin
            $display("mismatch at %0t: ALU rd %0d result %h illegal %b, expected rd %0d %h %b",
                     $time, alu_rd, alu_result, alu_illegal, a_exp[`XLEN+4:`XLEN],
                     a_exp[`XLEN-1:0], a_exp[`XLEN+5]);
            mismatch_errs++;
          end
        end
      end
      if (md_done) begin
        if (md_q.size() == 0) begin
          $display("error at %0t: md_done pulsed with no multiply/divide outstanding", $time);
          protocol_errs++;
        end else begin
          m_exp = md_q.pop_front();
          if ({md_rd, md_result} !== m_exp) begin
            $display("mismatch at %0t: MD rd %0d result %h, expected rd %0d result %h",
                     $time, md_rd, md_result, m_exp[`XLEN+4:`XLEN], m_exp[`XLEN-1:0]);
            mismatch_errs++;
          end
        end
      end
      // New expectations go in behind anything compared on this edge
      if (exp_valid) begin
        if (exp_md) begin
          md_q.push_back({exp_rd, exp_result});
        end else begin
          alu_q.push_back({exp_illegal, exp_rd, exp_result});
          alu_cycle_q.push_back(cycle);
        end
      end
    end
  end

  // Anything still queued at the end never got its done pulse
  always @(posedge end_check) begin
    if (alu_q.size() != 0) begin
      $display("error: %0d ALU results never arrived", alu_q.size());
      leftover_errs += alu_q.size();
    end
    if (md_q.size() != 0) begin
      $display("error: %0d multiply/divide results never arrived", md_q.size());
      leftover_errs += md_q.size();
    end
  end

endmodule

// File: dv/int_exec_tb.sv
// ================================================
// Integer execute slice testbench
// Applies a table of R-type instructions with their
// expected results and reports the checker counts
// ================================================

`timescale 1ns/1ps
`include "int_exec_defines.svh"

module int_exec_tb
  import int_exec_pkg::*;
();

  typedef struct packed {
    logic [6:0]       func7;
    logic [2:0]       func3;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] res;
    logic             illegal;
  } row_t;

  row_t             rows [$];
  logic             clk;
  logic             reset;
  logic             issue;
  logic [6:0]       func7;
  logic [2:0]       func3;
  logic [`XLEN-1:0] rs1;
  logic [`XLEN-1:0] rs2;
  logic [4:0]       rd;
  logic             exp_md;
  logic [`XLEN-1:0] exp_result;
  logic [4:0]       exp_rd;
  logic             exp_illegal;
  logic             end_check;
  logic             alu_done;
  logic [`XLEN-1:0] alu_result;
  logic [4:0]       alu_rd;
  logic             alu_illegal;
  logic             md_busy;
  logic             md_done;
  logic [`XLEN-1:0] md_result;
  logic [4:0]       md_rd;
  int               mismatch_count;
  int               other_count;

  int_exec_top dut0 (
    .clk (clk), .reset (reset), .issue (issue), .func7 (func7), .func3 (func3),
    .rs1 (rs1), .rs2 (rs2), .rd (rd),
    .alu_done (alu_done), .alu_result (alu_result), .alu_rd (alu_rd),
    .alu_illegal (alu_illegal), .md_busy (md_busy), .md_done (md_done),
    .md_result (md_result), .md_rd (md_rd)
  );

  // The expectation rides along with the issue strobe itself
  int_exec_checker chk0 (
    .clk (clk), .reset (reset), .exp_valid (issue), .exp_md (exp_md),
    .exp_result (exp_result), .exp_rd (exp_rd), .exp_illegal (exp_illegal),
    .end_check (end_check), .alu_done (alu_done), .alu_result (alu_result),
    .alu_rd (alu_rd), .alu_illegal (alu_illegal), .md_busy (md_busy),
    .md_done (md_done), .md_result (md_result), .md_rd (md_rd),
    .mismatch_count (mismatch_count), .other_count (other_count)
  );

  task automatic add_row(input logic [6:0] f7, input logic [2:0] f3,
                         input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                         input logic [`XLEN-1:0] res, input logic ill);
    row_t r;
    r.func7   = f7;
    r.func3   = f3;
    r.a       = a;
    r.b       = b;
    r.res     = res;
    r.illegal = ill;
    rows.push_back(r);
  endtask

  // M extension rows all share func7 0000001, func3 is the operation
  task automatic add_md(input md_op_e op, input logic [`XLEN-1:0] a,
                        input logic [`XLEN-1:0] b, input logic [`XLEN-1:0] res);
    add_row(7'b0000001, op, a, b, res, 1'b0);
  endtask

  task automatic build_table();
    // Base and Zbb arithmetic and logic around the sign boundary
    add_row(7'b0000000, 3'b000, 32'h7fffffff, 32'h00000001, 32'h80000000, 1'b0);
    add_row(7'b0100000, 3'b000, 32'h80000000, 32'h00000001, 32'h7fffffff, 1'b0);
    add_row(7'b0000000, 3'b100, 32'hf0f0f0f0, 32'h0ff00ff0, 32'hff00ff00, 1'b0);
    add_row(7'b0100000, 3'b100, 32'hf0f0f0f0, 32'h0ff00ff0, 32'h00ff00ff, 1'b0);
    add_row(7'b0000000, 3'b110, 32'h12340000, 32'h00005678, 32'h12345678, 1'b0);
    add_row(7'b0100000, 3'b110, 32'h00000000, 32'hffff0000, 32'h0000ffff, 1'b0);
    add_row(7'b0000000, 3'b111, 32'hf0f0f0f0, 32'h0ff00ff0, 32'h00f000f0, 1'b0);
    add_row(7'b0100000, 3'b111, 32'hffffffff, 32'h0000ff00, 32'hffff00ff, 1'b0);
    add_row(7'b0000000, 3'b010, 32'h80000000, 32'h7fffffff, 32'h00000001, 1'b0);
    add_row(7'b0000000, 3'b011, 32'h80000000, 32'h7fffffff, 32'h00000000, 1'b0);
    add_row(7'b0000101, 3'b100, 32'hffffffff, 32'h00000001, 32'hffffffff, 1'b0);
    add_row(7'b0000101, 3'b110, 32'hffffffff, 32'h00000001, 32'h00000001, 1'b0);
    add_row(7'b0000101, 3'b101, 32'hffffffff, 32'h00000001, 32'h00000001, 1'b0);
    add_row(7'b0000101, 3'b111, 32'hffffffff, 32'h00000001, 32'hffffffff, 1'b0);
    // Shifts and rotates, where an amount of 32 wraps to 0
    add_row(7'b0000000, 3'b001, 32'h00000001, 32'h0000001f, 32'h80000000, 1'b0);
    add_row(7'b0000000, 3'b001, 32'h12345678, 32'h00000020, 32'h12345678, 1'b0);
    add_row(7'b0000000, 3'b101, 32'h80000000, 32'h0000001f, 32'h00000001, 1'b0);
    add_row(7'b0100000, 3'b101, 32'h80000000, 32'h0000001f, 32'hffffffff, 1'b0);
    add_row(7'b0100000, 3'b101, 32'h80000000, 32'h00000000, 32'h80000000, 1'b0);
    add_row(7'b0110000, 3'b001, 32'h80000001, 32'h00000001, 32'h00000003, 1'b0);
    add_row(7'b0110000, 3'b101, 32'h80000001, 32'h00000001, 32'hc0000000, 1'b0);
    add_row(7'b0110000, 3'b101, 32'h12345678, 32'h0000001f, 32'h2468acf0, 1'b0);
    // Shift-adds drop the bits shifted out of rs1, then ZEXT_H
    add_row(7'b0010000, 3'b010, 32'h00000010, 32'h00000001, 32'h00000021, 1'b0);
    add_row(7'b0010000, 3'b100, 32'h00000010, 32'h00000001, 32'h00000041, 1'b0);
    add_row(7'b0010000, 3'b110, 32'h40000000, 32'h00000005, 32'h00000005, 1'b0);
    add_row(7'b0000100, 3'b100, 32'h8765abcd, 32'h00000000, 32'h0000abcd, 1'b0);
    // Single-bit operations with the index taken modulo XLEN
    add_row(7'b0010100, 3'b001, 32'h00000000, 32'h00000023, 32'h00000008, 1'b0);
    add_row(7'b0010100, 3'b001, 32'h00000000, 32'h0000001f, 32'h80000000, 1'b0);
    add_row(7'b0100100, 3'b001, 32'hffffffff, 32'h00000000, 32'hfffffffe, 1'b0);
    add_row(7'b0110100, 3'b001, 32'h0000ffff, 32'h0000000f, 32'h00007fff, 1'b0);
    add_row(7'b0100100, 3'b101, 32'h80000000, 32'h0000001f, 32'h00000001, 1'b0);
    add_row(7'b0100100, 3'b101, 32'h80000000, 32'h00000000, 32'h00000000, 1'b0);
    // Zicond keeps rs1 or zero depending on rs2
    add_row(7'b0000111, 3'b101, 32'h12345678, 32'h00000000, 32'h00000000, 1'b0);
    add_row(7'b0000111, 3'b101, 32'h12345678, 32'h00000005, 32'h12345678, 1'b0);
    add_row(7'b0000111, 3'b111, 32'h12345678, 32'h00000000, 32'h12345678, 1'b0);
    add_row(7'b0000111, 3'b111, 32'h12345678, 32'h00000001, 32'h00000000, 1'b0);
    // Unrecognised encodings come back illegal with a zero result
    add_row(7'b1111111, 3'b000, 32'h12345678, 32'h87654321, 32'h00000000, 1'b1);
    add_row(7'b0010000, 3'b000, 32'h12345678, 32'h87654321, 32'h00000000, 1'b1);
    add_row(7'b0100000, 3'b001, 32'h12345678, 32'h87654321, 32'h00000000, 1'b1);
    // Multiplies with negative signed and large unsigned operands
    add_md(MD_MUL,    32'hfffffffe, 32'h00000003, 32'hfffffffa);
    add_md(MD_MULH,   32'h80000000, 32'h80000000, 32'h40000000);
    add_md(MD_MULH,   32'hfffffffe, 32'h00000003, 32'hffffffff);
    add_md(MD_MULHSU, 32'hffffffff, 32'hffffffff, 32'hffffffff);
    add_md(MD_MULHU,  32'hffffffff, 32'hffffffff, 32'hfffffffe);
    add_md(MD_MULHU,  32'h80000000, 32'h00000002, 32'h00000001);
    // Divides round toward zero, the remainder takes the dividend sign
    add_md(MD_DIV,    32'hffffffec, 32'h00000006, 32'hfffffffd);
    add_md(MD_REM,    32'hffffffec, 32'h00000006, 32'hfffffffe);
    add_md(MD_DIV,    32'h00000014, 32'hfffffffa, 32'hfffffffd);
    add_md(MD_REM,    32'h00000014, 32'hfffffffa, 32'h00000002);
    add_md(MD_DIVU,   32'hffffffec, 32'h00000006, 32'h2aaaaaa7);
    add_md(MD_REMU,   32'hffffffec, 32'h00000006, 32'h00000002);
    // Division by zero, then the most negative value over minus one
    add_md(MD_DIV,    32'h00001234, 32'h00000000, 32'hffffffff);
    add_md(MD_DIVU,   32'h00001234, 32'h00000000, 32'hffffffff);
    add_md(MD_REM,    32'h80000000, 32'h00000000, 32'h80000000);
    add_md(MD_REMU,   32'hffffffec, 32'h00000000, 32'hffffffec);
    add_md(MD_DIV,    32'h80000000, 32'hffffffff, 32'h80000000);
    add_md(MD_REM,    32'h80000000, 32'hffffffff, 32'h00000000);
    // An ALU issue straight after the last md_done
    add_row(7'b0000000, 3'b000, 32'hffffffff, 32'h00000001, 32'h00000000, 1'b0);
  endtask

  task automatic apply_row(input int idx);
    func7       = rows[idx].func7;
    func3       = rows[idx].func3;
    rs1         = rows[idx].a;
    rs2         = rows[idx].b;
    rd          = 5'(idx);
    exp_md      = (rows[idx].func7 == 7'b0000001);
    exp_result  = rows[idx].res;
    exp_rd      = 5'(idx);
    exp_illegal = rows[idx].illegal;
    issue       = 1'b1;
  endtask

  // Waits out a running multiply/divide, checking 1 ns after each edge
  task automatic wait_md_idle();
    while (md_busy) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    issue       = 1'b0;
    func7       = '0;
    func3       = '0;
    rs1         = '0;
    rs2         = '0;
    rd          = '0;
    exp_md      = 1'b0;
    exp_result  = '0;
    exp_rd      = '0;
    exp_illegal = 1'b0;
    end_check   = 1'b0;
    reset       = 1'b1;
    build_table();
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      #1;
      issue = 1'b0;
      wait_md_idle();
      apply_row(i);
    end
    @(posedge clk);
    #1;
    issue = 1'b0;
    wait_md_idle();
    // Two more edges let the last done pulse reach the checker
    repeat (2) @(posedge clk);
    #1;
    end_check = 1'b1;
    #1;
    $display("checks done: %0d mismatches, %0d other errors", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Every row is allowed a full multiply/divide plus some slack
  initial begin
    longint limit_ns;
    #1;
    limit_ns = longint'(rows.size()) * (`MD_STEPS + 8) * 10 + 100;
    #(limit_ns);
    $display("timeout: the run did not finish within %0d ns", limit_ns);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: include/int_exec_defines.svh
// ================================================
// Integer execute slice configuration
// Operand width and the step count of the
// iterative multiply/divide datapath
// ================================================

`ifndef INT_EXEC_DEFINES_SVH
`define INT_EXEC_DEFINES_SVH

// Width of both source operands and of every result
`define XLEN 32

// The multiply/divide unit retires one operand bit per cycle,
// so a full operation takes one step for every bit of XLEN
`define MD_STEPS `XLEN

`endif

// File: list.f
+incdir+include
rtl/int_exec_pkg.sv
rtl/decoded_op_if.sv
rtl/op_dec.sv
rtl/int_alu.sv
rtl/muldiv_unit.sv
rtl/int_exec_top.sv
dv/int_exec_checker.sv
dv/int_exec_tb.sv

// File: rtl/decoded_op_if.sv
// ================================================
// Decoded operation bundle
// Carries the decoder output to both execution units
// ================================================

`timescale 1ns/1ps

interface decoded_op_if;

  // Operation code holding an alu_op_e value or func3 for mul/div
  logic [6:0] uop;
  // At most one of the class flags is set
  logic       mul;
  logic       div;
  // Low for any encoding the decoder does not recognise
  logic       legal;

  // The decoder is the only driver of the bundle
  modport dec (output uop, output mul, output div, output legal);

  // Both units only look at the decoded operation
  modport unit (input uop, input mul, input div, input legal);

endinterface

// File: rtl/int_alu.sv
// ================================================
// Single-cycle integer ALU
// Base, Zba, Zbb, Zbs and Zicond operations with a
// registered result one cycle after issue
// ================================================

`timescale 1ns/1ps
`include "int_exec_defines.svh"

module int_alu
  import int_exec_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              issue,
  input  logic [`XLEN-1:0]  rs1,
  input  logic [`XLEN-1:0]  rs2,
  input  logic [4:0]        rd,
  decoded_op_if.unit        op,
  output logic              done,
  output logic [`XLEN-1:0]  result,
  output logic [4:0]        rd_out,
  output logic              illegal
);

  // Shift amounts and bit indices are taken modulo XLEN
  localparam int SHW = $clog2(`XLEN);

  alu_op_e              uop;
  logic [SHW-1:0]       shamt;
  logic [`XLEN-1:0]     bit_mask;
  logic [2*`XLEN-1:0]   rol_wide;
  logic [2*`XLEN-1:0]   ror_wide;
  logic                 lt_s;
  logic                 lt_u;
  logic                 rs2_zero;
  logic [`XLEN-1:0]     alu_out;
  logic                 accept;

  assign uop      = alu_op_e'(op.uop);
  assign shamt    = rs2[SHW-1:0];
  assign bit_mask = {{(`XLEN-1){1'b0}}, 1'b1} << shamt;
  assign rs2_zero = (rs2 == '0);

  // Rotates shift a doubled copy of rs1 and keep the wrapped half
  assign rol_wide = {rs1, rs1} << shamt;
  assign ror_wide = {rs1, rs1} >> shamt;

  // One comparator pair feeds SLT, SLTU and the min/max selects
  assign lt_s = ($signed(rs1) < $signed(rs2));
  assign lt_u = (rs1 < rs2);

  always_comb begin
    case (uop)
      ALU_ADD:       alu_out = rs1 + rs2;
      ALU_SUB:       alu_out = rs1 - rs2;
      ALU_SH1ADD:    alu_out = (rs1 << 1) + rs2;
      ALU_SH2ADD:    alu_out = (rs1 << 2) + rs2;
      ALU_SH3ADD:    alu_out = (rs1 << 3) + rs2;
      ALU_ZEXT_H:    alu_out = {{(`XLEN-16){1'b0}}, rs1[15:0]};
      ALU_SLL:       alu_out = rs1 << shamt;
      ALU_SRL:       alu_out = rs1 >> shamt;
      ALU_SRA:       alu_out = $signed(rs1) >>> shamt;
      ALU_ROL:       alu_out = rol_wide[2*`XLEN-1:`XLEN];
      ALU_ROR:       alu_out = ror_wide[`XLEN-1:0];
      ALU_BCLR:      alu_out = rs1 & ~bit_mask;
      ALU_BSET:      alu_out = rs1 | bit_mask;
      ALU_BINV:      alu_out = rs1 ^ bit_mask;
      ALU_BEXT:      alu_out = {{(`XLEN-1){1'b0}}, rs1[shamt]};
      ALU_SLT:       alu_out = {{(`XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:      alu_out = {{(`XLEN-1){1'b0}}, lt_u};
      ALU_MIN:       alu_out = lt_s ? rs1 : rs2;
      ALU_MAX:       alu_out = lt_s ? rs2 : rs1;
      ALU_MINU:      alu_out = lt_u ? rs1 : rs2;
      ALU_MAXU:      alu_out = lt_u ? rs2 : rs1;
      // Zicond passes rs1 through unless the condition zeroes it
      ALU_CZERO_EQZ: alu_out = rs2_zero ? '0 : rs1;
      ALU_CZERO_NEZ: alu_out = rs2_zero ? rs1 : '0;
      ALU_AND:       alu_out = rs1 & rs2;
      ALU_OR:        alu_out = rs1 | rs2;
      ALU_XOR:       alu_out = rs1 ^ rs2;
      ALU_ANDN:      alu_out = rs1 & ~rs2;
      ALU_ORN:       alu_out = rs1 | ~rs2;
      ALU_XNOR:      alu_out = ~(rs1 ^ rs2);
      default:       alu_out = '0;
    endcase
  end

  // Illegal encodings carry no class flag and land here as well
  assign accept = issue & ~op.mul & ~op.div;

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= accept;
    end
  end

  // Result, tag and flag only change when the ALU takes an issue
  always_ff @(posedge clk) begin
    if (accept) begin
      result  <= op.legal ? alu_out : '0;
      rd_out  <= rd;
      illegal <= ~op.legal;
    end
  end

  // An illegal encoding must reach this unit and never the multiply/divide unit
  a_illegal_no_class: assert property (
    @(posedge clk) disable iff (reset)
    issue && !op.legal |-> !op.mul && !op.div
  );

endmodule

// File: rtl/int_exec_pkg.sv
// ================================================
// Integer execute package
// Operation codes shared by the decoder, the ALU
// and the multiply/divide unit
// ================================================

package int_exec_pkg;

  // Single-cycle operation codes, grouped so that the top two bits
  // roughly follow the adder, shifter, compare and logic groups
  typedef enum logic [6:0] {
    ALU_ADD       = 7'b0000000,
    ALU_SH1ADD    = 7'b0000001,
    ALU_SH2ADD    = 7'b0000010,
    ALU_SH3ADD    = 7'b0000011,
    ALU_SUB       = 7'b0000100,
    ALU_ZEXT_H    = 7'b0001010,
    ALU_SLL       = 7'b0100000,
    ALU_SRL       = 7'b0100001,
    ALU_ROL       = 7'b0100010,
    ALU_ROR       = 7'b0100011,
    ALU_SRA       = 7'b0100101,
    ALU_BCLR      = 7'b0101000,
    ALU_BEXT      = 7'b0101011,
    ALU_BINV      = 7'b0111000,
    ALU_BSET      = 7'b0111010,
    ALU_MAXU      = 7'b1000000,
    ALU_MINU      = 7'b1000001,
    ALU_SLT       = 7'b1000010,
    ALU_SLTU      = 7'b1000011,
    ALU_MAX       = 7'b1000100,
    ALU_MIN       = 7'b1000101,
    ALU_CZERO_EQZ = 7'b1000110,
    ALU_CZERO_NEZ = 7'b1000111,
    ALU_AND       = 7'b1100000,
    ALU_OR        = 7'b1100001,
    ALU_XOR       = 7'b1100010,
    ALU_ANDN      = 7'b1100100,
    ALU_ORN       = 7'b1100101,
    ALU_XNOR      = 7'b1100110
  } alu_op_e;

  // Multiply/divide codes are exactly the func3 field of the M extension
  typedef enum logic [2:0] {
    MD_MUL    = 3'b000,
    MD_MULH   = 3'b001,
    MD_MULHSU = 3'b010,
    MD_MULHU  = 3'b011,
    MD_DIV    = 3'b100,
    MD_DIVU   = 3'b101,
    MD_REM    = 3'b110,
    MD_REMU   = 3'b111
  } md_op_e;

endpackage

// File: rtl/int_exec_top.sv
// ================================================
// Integer execute slice top level
// Decoder feeding the ALU and the multiply/divide
// unit, each with its own result ports
// ================================================

`timescale 1ns/1ps
`include "int_exec_defines.svh"

module int_exec_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              issue,
  input  logic [6:0]        func7,
  input  logic [2:0]        func3,
  input  logic [`XLEN-1:0]  rs1,
  input  logic [`XLEN-1:0]  rs2,
  input  logic [4:0]        rd,
  output logic              alu_done,
  output logic [`XLEN-1:0]  alu_result,
  output logic [4:0]        alu_rd,
  output logic              alu_illegal,
  output logic              md_busy,
  output logic              md_done,
  output logic [`XLEN-1:0]  md_result,
  output logic [4:0]        md_rd
);

  // Decoded operation shared by both units in the issue cycle
  decoded_op_if dec_if ();

  op_dec u_op_dec (
    .func7 (func7),
    .func3 (func3),
    .dec   (dec_if.dec)
  );

  // Takes every issue without a mul/div class, illegal ones included
  int_alu u_int_alu (
    .clk     (clk),
    .reset   (reset),
    .issue   (issue),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .op      (dec_if.unit),
    .done    (alu_done),
    .result  (alu_result),
    .rd_out  (alu_rd),
    .illegal (alu_illegal)
  );

  muldiv_unit u_muldiv_unit (
    .clk    (clk),
    .reset  (reset),
    .issue  (issue),
    .rs1    (rs1),
    .rs2    (rs2),
    .rd     (rd),
    .op     (dec_if.unit),
    .busy   (md_busy),
    .done   (md_done),
    .result (md_result),
    .rd_out (md_rd)
  );

endmodule

// File: rtl/muldiv_unit.sv
// ================================================
// Iterative multiply/divide unit
// Shift-add multiplier and restoring divider over
// unsigned magnitudes, one bit per cycle
// ================================================

`timescale 1ns/1ps
`include "int_exec_defines.svh"

module muldiv_unit
  import int_exec_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              issue,
  input  logic [`XLEN-1:0]  rs1,
  input  logic [`XLEN-1:0]  rs2,
  input  logic [4:0]        rd,
  decoded_op_if.unit        op,
  output logic              busy,
  output logic              done,
  output logic [`XLEN-1:0]  result,
  output logic [4:0]        rd_out
);

  // The counter has to reach MD_STEPS itself to mark the finish cycle
  localparam int CW = $clog2(`MD_STEPS + 1);

  md_op_e               issue_op;
  logic                 accept;
  logic                 sign_a;
  logic                 sign_b;
  logic [`XLEN-1:0]     mag_a;
  logic [`XLEN-1:0]     mag_b;
  md_op_e               md_op;
  logic                 is_div;
  logic                 neg_lo;
  logic                 neg_hi;
  logic                 div_zero;
  logic                 div_ovf;
  logic [`XLEN-1:0]     dividend;
  logic [`XLEN-1:0]     opnd;
  logic [2*`XLEN-1:0]   acc;
  logic [CW-1:0]        step_cnt;
  logic                 last_step;
  logic [`XLEN:0]       mul_sum;
  logic [2*`XLEN-1:0]   mul_next;
  logic [`XLEN:0]       div_trial;
  logic [`XLEN:0]       div_diff;
  logic [2*`XLEN-1:0]   div_next;
  logic [2*`XLEN-1:0]   prod;
  logic [`XLEN-1:0]     quot;
  logic [`XLEN-1:0]     rem;
  logic [`XLEN-1:0]     final_res;

  assign issue_op = md_op_e'(op.uop[2:0]);
  assign accept   = issue & (op.mul | op.div);

  // MULHSU treats only rs1 as signed, DIV and REM treat both as signed
  assign sign_a = rs1[`XLEN-1] & (issue_op inside {MD_MULH, MD_MULHSU, MD_DIV, MD_REM});
  assign sign_b = rs2[`XLEN-1] & (issue_op inside {MD_MULH, MD_DIV, MD_REM});
  assign mag_a  = sign_a ? -rs1 : rs1;
  assign mag_b  = sign_b ? -rs2 : rs2;

  assign last_step = (step_cnt == CW'(`MD_STEPS));

  // Multiply step adds the multiplicand on a set multiplier bit, then shifts right
  assign mul_sum  = {1'b0, acc[2*`XLEN-1:`XLEN]} + (acc[0] ? {1'b0, opnd} : '0);
  assign mul_next = {mul_sum, acc[`XLEN-1:1]};

  // Divide step shifts the next dividend bit into the partial remainder
  // and keeps the difference only when the subtraction does not borrow
  assign div_trial = acc[2*`XLEN-1:`XLEN-1];
  assign div_diff  = div_trial - {1'b0, opnd};
  assign div_next  = div_diff[`XLEN] ? {div_trial[`XLEN-1:0], acc[`XLEN-2:0], 1'b0}
                                     : {div_diff[`XLEN-1:0], acc[`XLEN-2:0], 1'b1};

  // Sign correction and word select feed the result register in the finish cycle
  always_comb begin
    prod = neg_lo ? -acc : acc;
    quot = neg_lo ? -acc[`XLEN-1:0] : acc[`XLEN-1:0];
    rem  = neg_hi ? -acc[2*`XLEN-1:`XLEN] : acc[2*`XLEN-1:`XLEN];
    case (md_op)
      MD_MUL:                       final_res = prod[`XLEN-1:0];
      MD_MULH, MD_MULHSU, MD_MULHU: final_res = prod[2*`XLEN-1:`XLEN];
      MD_DIV, MD_DIVU:              final_res = div_zero ? '1 : (div_ovf ? dividend : quot);
      default:                      final_res = div_zero ? dividend : (div_ovf ? '0 : rem);
    endcase
  end

  // busy spans the load edge up to the finish edge, where done pulses
  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      step_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (accept) begin
        busy     <= 1'b1;
        step_cnt <= '0;
      end else if (busy) begin
        if (last_step) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          step_cnt <= step_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      md_op    <= issue_op;
      is_div   <= op.div;
      rd_out   <= rd;
      dividend <= rs1;
      neg_lo   <= sign_a ^ sign_b;
      neg_hi   <= sign_a;
      div_zero <= (rs2 == '0);
      // Most negative value divided by minus one overflows
      div_ovf  <= (issue_op inside {MD_DIV, MD_REM}) &&
                  (rs1 == {1'b1, {(`XLEN-1){1'b0}}}) && (&rs2);
      // The multiplier and the dividend both start in the low half
      opnd     <= op.div ? mag_b : mag_a;
      acc      <= {{`XLEN{1'b0}}, (op.div ? mag_a : mag_b)};
    end else if (busy && !last_step) begin
      acc <= is_div ? div_next : mul_next;
    end
    if (busy && last_step) begin
      result <= final_res;
    end
  end

  // The issuer holds issue low for the whole multi-cycle operation
  a_no_issue_while_busy: assert property (
    @(posedge clk) disable iff (reset) busy |-> !issue
  );

  // done is registered MD_STEPS+1 edges after the issue edge and seen one edge later
  a_done_latency: assert property (
    @(posedge clk) disable iff (reset) done |-> $past(accept, `MD_STEPS + 2)
  );

endmodule

// File: rtl/op_dec.sv
// ================================================
// R-type operation decoder
// Maps func7/func3 to an operation code, the
// mul/div class flags and a legality bit
// ================================================

`timescale 1ns/1ps

module op_dec
  import int_exec_pkg::*;
(
  input  logic [6:0] func7,
  input  logic [2:0] func3,
  decoded_op_if.dec  dec
);

  // func7 values of the recognised register-register encodings
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_MD     = 7'b0000001;
  // SUB, SRA, XNOR, ORN and ANDN share this one
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_SHADD  = 7'b0010000;
  localparam logic [6:0] F7_ZEXT   = 7'b0000100;
  localparam logic [6:0] F7_MINMAX = 7'b0000101;
  localparam logic [6:0] F7_CZERO  = 7'b0000111;
  localparam logic [6:0] F7_BSET   = 7'b0010100;
  // BCLR in the 001 column and BEXT in the 101 column
  localparam logic [6:0] F7_BCLR   = 7'b0100100;
  localparam logic [6:0] F7_BINV   = 7'b0110100;
  localparam logic [6:0] F7_ROT    = 7'b0110000;

  alu_op_e alu_op;
  logic    alu_legal;
  logic    muldiv;

  // Single-cycle table, one entry per func3 column and func7 value
  always_comb begin
    alu_op    = ALU_ADD;
    alu_legal = 1'b1;
    case ({func3, func7})
      {3'b000, F7_BASE}:   alu_op = ALU_ADD;
      {3'b000, F7_ALT}:    alu_op = ALU_SUB;
      {3'b001, F7_BASE}:   alu_op = ALU_SLL;
      {3'b001, F7_BSET}:   alu_op = ALU_BSET;
      {3'b001, F7_BCLR}:   alu_op = ALU_BCLR;
      {3'b001, F7_BINV}:   alu_op = ALU_BINV;
      {3'b001, F7_ROT}:    alu_op = ALU_ROL;
      {3'b010, F7_BASE}:   alu_op = ALU_SLT;
      {3'b010, F7_SHADD}:  alu_op = ALU_SH1ADD;
      {3'b011, F7_BASE}:   alu_op = ALU_SLTU;
      {3'b100, F7_BASE}:   alu_op = ALU_XOR;
      {3'b100, F7_ZEXT}:   alu_op = ALU_ZEXT_H;
      {3'b100, F7_ALT}:    alu_op = ALU_XNOR;
      {3'b100, F7_MINMAX}: alu_op = ALU_MIN;
      {3'b100, F7_SHADD}:  alu_op = ALU_SH2ADD;
      {3'b101, F7_BASE}:   alu_op = ALU_SRL;
      {3'b101, F7_ALT}:    alu_op = ALU_SRA;
      {3'b101, F7_BCLR}:   alu_op = ALU_BEXT;
      {3'b101, F7_MINMAX}: alu_op = ALU_MINU;
      {3'b101, F7_ROT}:    alu_op = ALU_ROR;
      {3'b101, F7_CZERO}:  alu_op = ALU_CZERO_EQZ;
      {3'b110, F7_BASE}:   alu_op = ALU_OR;
      {3'b110, F7_MINMAX}: alu_op = ALU_MAX;
      {3'b110, F7_ALT}:    alu_op = ALU_ORN;
      {3'b110, F7_SHADD}:  alu_op = ALU_SH3ADD;
      {3'b111, F7_BASE}:   alu_op = ALU_AND;
      {3'b111, F7_ALT}:    alu_op = ALU_ANDN;
      {3'b111, F7_MINMAX}: alu_op = ALU_MAXU;
      {3'b111, F7_CZERO}:  alu_op = ALU_CZERO_NEZ;
      default:             alu_legal = 1'b0;
    endcase
  end

  // Every func3 column holds one M-extension operation
  assign muldiv = (func7 == F7_MD);

  // Bit 2 of func3 separates the divides from the multiplies
  assign dec.mul   = muldiv & ~func3[2];
  assign dec.div   = muldiv & func3[2];
  assign dec.uop   = muldiv ? {4'b0000, func3} : alu_op;
  assign dec.legal = muldiv | alu_legal;

endmodule
